// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing -f files.f --top-module tb_rv_core
	-./obj_dir/Vtb_rv_core > sim.log 2>&1
	cat sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu.sv ====
`timescale 1ns/1ps

module alu
    import rv_pkg::*;
(
    input  alu_op_e     alu_op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'd0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            // Arithmetic shift keeps the sign of a
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            // LUI passes the U immediate straight through
            ALU_PASS_B: result = b;
            default:    result = '0;
        endcase
    end

endmodule

// ==== decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        f_valid,
    output logic        f_ready,
    input  fetch_pkt_t  f_pkt,
    output logic [4:0]  rs1_addr,
    output logic [4:0]  rs2_addr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        d_valid,
    input  logic        d_ready,
    output decode_pkt_t d_pkt
);

    logic [31:0] instr;
    logic [31:0] imm;
    ctrl_t       ctrl;
    logic        f_fire;

    assign instr    = f_pkt.instr;
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    // Take a new word when the output slot is free or draining
    assign f_ready = !d_valid || d_ready;
    assign f_fire  = f_valid && f_ready;

    instr_decoder u_instr_decoder (
        .opcode      (instr[6:0]),
        .funct3      (instr[14:12]),
        .funct7      (instr[31:25]),
        .funct12_bit (instr[20]),
        .ctrl        (ctrl)
    );

    always_comb begin
        case (ctrl.imm_sel)
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'd0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else if (f_fire) begin
            d_valid <= 1'b1;
        end else if (d_ready) begin
            d_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (f_fire) begin
            d_pkt.pc      <= f_pkt.pc;
            d_pkt.rs1_val <= rs1_data;
            d_pkt.rs2_val <= rs2_data;
            d_pkt.imm     <= imm;
            d_pkt.rd      <= instr[11:7];
            d_pkt.funct3  <= instr[14:12];
            d_pkt.ctrl    <= ctrl;
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        d_valid,
    output logic        d_ready,
    input  decode_pkt_t d_pkt,
    output wb_req_t     dbus_req,
    input  wb_rsp_t     dbus_rsp,
    output logic        wr_en,
    output logic [4:0]  wr_addr,
    output logic [31:0] wr_data,
    output logic        redirect_valid,
    output logic [31:0] next_pc,
    output logic        halted,
    output logic        illegal
);

    typedef enum logic {IDLE, MEM} exec_state_e;

    exec_state_e state;
    logic        d_fire;
    logic        is_mem;
    logic        taken;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] pc_plus4;
    logic [31:0] target;
    logic [31:0] wb_data;
    logic        cyc_q;
    logic        we_q;
    logic        rw_q;
    logic [31:0] adr_q;
    logic [31:0] dat_w_q;

    assign d_ready = (state == IDLE);
    assign d_fire  = d_valid && d_ready;
    assign is_mem  = d_pkt.ctrl.mem_read || d_pkt.ctrl.mem_write;

    assign op_a = d_pkt.ctrl.src_a_pc ? d_pkt.pc : d_pkt.rs1_val;
    assign op_b = d_pkt.ctrl.src_b_imm ? d_pkt.imm : d_pkt.rs2_val;

    alu u_alu (
        .alu_op (d_pkt.ctrl.alu_op),
        .a      (op_a),
        .b      (op_b),
        .result (alu_result)
    );

    // Branch condition from funct3
    always_comb begin
        case (d_pkt.funct3)
            3'b000:  taken = (d_pkt.rs1_val == d_pkt.rs2_val);
            3'b001:  taken = (d_pkt.rs1_val != d_pkt.rs2_val);
            3'b100:  taken = ($signed(d_pkt.rs1_val) < $signed(d_pkt.rs2_val));
            3'b101:  taken = ($signed(d_pkt.rs1_val) >= $signed(d_pkt.rs2_val));
            3'b110:  taken = (d_pkt.rs1_val < d_pkt.rs2_val);
            3'b111:  taken = (d_pkt.rs1_val >= d_pkt.rs2_val);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = d_pkt.pc + 32'd4;

    always_comb begin
        if (d_pkt.ctrl.jalr) begin
            target = {alu_result[31:1], 1'b0};
        end else if (d_pkt.ctrl.jump || (d_pkt.ctrl.branch && taken)) begin
            target = d_pkt.pc + d_pkt.imm;
        end else begin
            target = pc_plus4;
        end
    end

    assign wb_data = (d_pkt.ctrl.result_sel == RES_PC4) ? pc_plus4 : alu_result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= IDLE;
            cyc_q          <= 1'b0;
            we_q           <= 1'b0;
            rw_q           <= 1'b0;
            wr_en          <= 1'b0;
            redirect_valid <= 1'b0;
            halted         <= 1'b0;
            illegal        <= 1'b0;
        end else begin
            wr_en          <= 1'b0;
            redirect_valid <= 1'b0;
            if (state == IDLE && d_fire) begin
                if (d_pkt.ctrl.halt) begin
                    halted  <= 1'b1;
                    illegal <= d_pkt.ctrl.illegal;
                end else if (is_mem) begin
                    state <= MEM;
                    cyc_q <= 1'b1;
                    we_q  <= d_pkt.ctrl.mem_write;
                    rw_q  <= d_pkt.ctrl.reg_write;
                end else begin
                    wr_en          <= d_pkt.ctrl.reg_write;
                    redirect_valid <= 1'b1;
                end
            end else if (state == MEM && dbus_rsp.ack) begin
                // Load data lands in the register file with the redirect
                state          <= IDLE;
                cyc_q          <= 1'b0;
                we_q           <= 1'b0;
                wr_en          <= rw_q;
                redirect_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (d_fire) begin
            wr_addr <= d_pkt.rd;
            if (is_mem) begin
                next_pc <= pc_plus4;
                adr_q   <= alu_result;
                dat_w_q <= d_pkt.rs2_val;
            end else begin
                next_pc <= target;
                wr_data <= wb_data;
            end
        end else if (state == MEM && dbus_rsp.ack) begin
            wr_data <= dbus_rsp.dat_r;
        end
    end

    assign dbus_req = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat_w: dat_w_q};

endmodule

// ==== fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import rv_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    output wb_req_t     ibus_req,
    input  wb_rsp_t     ibus_rsp,
    output logic        f_valid,
    input  logic        f_ready,
    output fetch_pkt_t  f_pkt,
    input  logic        redirect_valid,
    input  logic [31:0] next_pc
);

    typedef enum logic [1:0] {BUS, HOLD, WAIT} fetch_state_e;

    fetch_state_e state;
    logic         cyc_q;
    logic [31:0]  pc_q;
    logic [31:0]  instr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BUS;
            cyc_q <= 1'b0;
            pc_q  <= RESET_PC;
        end else begin
            case (state)
                BUS: begin
                    // Idle bus in BUS only happens right after reset
                    if (!cyc_q) begin
                        cyc_q <= 1'b1;
                    end else if (ibus_rsp.ack) begin
                        cyc_q <= 1'b0;
                        state <= HOLD;
                    end
                end
                HOLD: if (f_ready) state <= WAIT;
                // Stays here for good once a halting instruction retires
                WAIT: begin
                    if (redirect_valid) begin
                        pc_q  <= next_pc;
                        cyc_q <= 1'b1;
                        state <= BUS;
                    end
                end
                default: state <= BUS;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == BUS && cyc_q && ibus_rsp.ack) instr_q <= ibus_rsp.dat_r;
    end

    assign ibus_req = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: pc_q, dat_w: '0};
    assign f_valid  = (state == HOLD);
    assign f_pkt    = '{pc: pc_q, instr: instr_q};

endmodule

// ==== files.f ====
rv_pkg.sv
reg_file.sv
alu.sv
instr_decoder.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
rv_core.sv
tb_rv_core.sv

// ==== instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder
    import rv_pkg::*;
(
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       funct12_bit,
    output ctrl_t      ctrl
);

    always_comb begin
        ctrl            = '0;
        ctrl.alu_op     = ALU_ADD;
        ctrl.imm_sel    = IMM_I;
        ctrl.result_sel = RES_ALU;

        // Pattern is opcode, funct3, funct7, then instruction bit 20
        casez ({opcode, funct3, funct7, funct12_bit})
            {OP_LUI, 11'b?}: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.imm_sel   = IMM_U;
            end
            {OP_AUIPC, 11'b?}: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm_sel   = IMM_U;
            end
            {OP_JAL, 11'b?}: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.imm_sel    = IMM_J;
                ctrl.result_sel = RES_PC4;
            end
            {OP_JALR, 3'b000, 8'b?}: begin
                ctrl.reg_write  = 1'b1;
                ctrl.jump       = 1'b1;
                ctrl.jalr       = 1'b1;
                ctrl.src_b_imm  = 1'b1;
                ctrl.result_sel = RES_PC4;
            end
            // BEQ, BNE and the four ordered compares
            {OP_BRANCH, 3'b00?, 8'b?},
            {OP_BRANCH, 3'b1??, 8'b?}: begin
                ctrl.branch  = 1'b1;
                ctrl.imm_sel = IMM_B;
            end
            {OP_LOAD, 3'b010, 8'b?}: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.src_b_imm  = 1'b1;
                ctrl.result_sel = RES_LOAD;
            end
            {OP_STORE, 3'b010, 8'b?}: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.imm_sel   = IMM_S;
            end
            // ALU operation for the register and immediate forms
            {OP_R, 3'b000, F7_BASE, 1'b?}, {OP_IMM, 3'b000, 8'b?}: ctrl.alu_op = ALU_ADD;
            {OP_R, 3'b000, F7_ALT, 1'b?}: ctrl.alu_op = ALU_SUB;
            {OP_R, 3'b001, F7_BASE, 1'b?}, {OP_IMM, 3'b001, F7_BASE, 1'b?}: ctrl.alu_op = ALU_SLL;
            {OP_R, 3'b010, F7_BASE, 1'b?}, {OP_IMM, 3'b010, 8'b?}: ctrl.alu_op = ALU_SLT;
            {OP_R, 3'b011, F7_BASE, 1'b?}, {OP_IMM, 3'b011, 8'b?}: ctrl.alu_op = ALU_SLTU;
            {OP_R, 3'b100, F7_BASE, 1'b?}, {OP_IMM, 3'b100, 8'b?}: ctrl.alu_op = ALU_XOR;
            {OP_R, 3'b101, F7_BASE, 1'b?}, {OP_IMM, 3'b101, F7_BASE, 1'b?}: ctrl.alu_op = ALU_SRL;
            {OP_R, 3'b101, F7_ALT, 1'b?}, {OP_IMM, 3'b101, F7_ALT, 1'b?}: ctrl.alu_op = ALU_SRA;
            {OP_R, 3'b110, F7_BASE, 1'b?}, {OP_IMM, 3'b110, 8'b?}: ctrl.alu_op = ALU_OR;
            {OP_R, 3'b111, F7_BASE, 1'b?}, {OP_IMM, 3'b111, 8'b?}: ctrl.alu_op = ALU_AND;
            // Fence retires with no side effect
            {OP_FENCE, 3'b000, 8'b?}: ctrl.halt = 1'b0;
            // ECALL
            {OP_SYSTEM, 3'b000, F7_BASE, 1'b0}: ctrl.halt = 1'b1;
            // EBREAK
            {OP_SYSTEM, 3'b000, F7_BASE, 1'b1}: ctrl.halt = 1'b1;
            default: begin
                ctrl.halt    = 1'b1;
                ctrl.illegal = 1'b1;
            end
        endcase

        // Common controls for a legal ALU instruction
        if ((opcode == OP_R || opcode == OP_IMM) && !ctrl.illegal) begin
            ctrl.reg_write = 1'b1;
            ctrl.src_b_imm = (opcode == OP_IMM);
        end
    end

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs1_addr,
    input  logic [4:0]  rs2_addr,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core
    import rv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    output wb_req_t ibus_req,
    input  wb_rsp_t ibus_rsp,
    output wb_req_t dbus_req,
    input  wb_rsp_t dbus_rsp,
    output logic    halted,
    output logic    illegal
);

    logic        f_valid;
    logic        f_ready;
    fetch_pkt_t  f_pkt;
    logic        d_valid;
    logic        d_ready;
    decode_pkt_t d_pkt;
    logic [4:0]  rs1_addr;
    logic [4:0]  rs2_addr;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wr_en;
    logic [4:0]  wr_addr;
    logic [31:0] wr_data;
    logic        redirect_valid;
    logic [31:0] next_pc;

    fetch_stage u_fetch_stage (
        .clk(clk), .rst_n(rst_n),
        .ibus_req(ibus_req), .ibus_rsp(ibus_rsp),
        .f_valid(f_valid), .f_ready(f_ready), .f_pkt(f_pkt),
        .redirect_valid(redirect_valid), .next_pc(next_pc)
    );

    decode_stage u_decode_stage (
        .clk(clk), .rst_n(rst_n),
        .f_valid(f_valid), .f_ready(f_ready), .f_pkt(f_pkt),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .d_valid(d_valid), .d_ready(d_ready), .d_pkt(d_pkt)
    );

    execute_stage u_execute_stage (
        .clk(clk), .rst_n(rst_n),
        .d_valid(d_valid), .d_ready(d_ready), .d_pkt(d_pkt),
        .dbus_req(dbus_req), .dbus_rsp(dbus_rsp),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .redirect_valid(redirect_valid), .next_pc(next_pc),
        .halted(halted), .illegal(illegal)
    );

    reg_file u_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

endmodule

// ==== rv_pkg.sv ====
package rv_pkg;

    // Pc value out of reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // Funct7 values for the base and alternate ALU encodings
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_JALR   = 7'b1100111,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_FENCE  = 7'b0001111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {RES_ALU, RES_LOAD, RES_PC4} result_sel_e;

    typedef struct packed {
        logic        reg_write;
        logic        mem_write;
        logic        mem_read;
        logic        jump;
        logic        branch;
        logic        jalr;
        logic        src_a_pc;
        logic        src_b_imm;
        alu_op_e     alu_op;
        imm_sel_e    imm_sel;
        result_sel_e result_sel;
        logic        halt;
        logic        illegal;
    } ctrl_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [2:0]  funct3;
        ctrl_t       ctrl;
    } decode_pkt_t;

    // Wishbone classic master request and slave response
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core
    import rv_pkg::*;
();

    localparam logic [6:0]  OPC_IMM   = 7'b0010011;
    localparam logic [6:0]  OPC_LUI   = 7'b0110111;
    localparam logic [6:0]  OPC_AUIPC = 7'b0010111;
    localparam logic [6:0]  OPC_JALR  = 7'b1100111;
    localparam logic [31:0] ECALL     = 32'h0000_0073;
    localparam logic [31:0] EBREAK    = 32'h0010_0073;

    logic        clk;
    logic        rst_n;
    wb_req_t     ibus_req;
    wb_rsp_t     ibus_rsp = '0;
    wb_req_t     dbus_req;
    wb_rsp_t     dbus_rsp = '0;
    logic        halted;
    logic        illegal;

    logic [31:0] imem [256];
    logic [31:0] dmem [256];
    int          prog_len;
    wb_req_t     ireq_s;
    wb_req_t     dreq_s;
    logic [1:0]  iwait = '0;
    logic [1:0]  dwait = '0;
    logic [31:0] fetch_log [$];
    logic [31:0] dbus_adr_log [$];
    logic [31:0] dbus_dat_log [$];
    logic        dbus_we_log [$];

    rv_core u_rv_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .ibus_req (ibus_req),
        .ibus_rsp (ibus_rsp),
        .dbus_req (dbus_req),
        .dbus_rsp (dbus_rsp),
        .halted   (halted),
        .illegal  (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction slave acks once after 0 to 3 wait cycles
    always @(posedge clk) begin
        ireq_s = ibus_req;
        #1;
        if (ibus_rsp.ack || !ireq_s.cyc || !ireq_s.stb) begin
            ibus_rsp.ack = 1'b0;
            iwait        = 2'($urandom_range(3, 0));
        end else if (iwait == 2'd0) begin
            compare("ibus_req.we", 32'(ireq_s.we), 32'd0);
            ibus_rsp.ack   = 1'b1;
            ibus_rsp.dat_r = imem[ireq_s.adr[9:2]];
            fetch_log.push_back(ireq_s.adr);
        end else begin
            iwait = iwait - 2'd1;
        end
    end

    // Data slave reads the preloaded words and records every bus cycle
    always @(posedge clk) begin
        dreq_s = dbus_req;
        #1;
        if (dbus_rsp.ack || !dreq_s.cyc || !dreq_s.stb) begin
            dbus_rsp.ack = 1'b0;
            dwait        = 2'($urandom_range(3, 0));
        end else if (dwait == 2'd0) begin
            dbus_rsp.ack   = 1'b1;
            dbus_rsp.dat_r = dmem[dreq_s.adr[9:2]];
            dbus_adr_log.push_back(dreq_s.adr);
            dbus_dat_log.push_back(dreq_s.dat_w);
            dbus_we_log.push_back(dreq_s.we);
        end else begin
            dwait = dwait - 2'd1;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
        return i_type(OPC_IMM, 3'b000, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return i_type(7'b0000011, 3'b010, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                       input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
                                           input logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            stop_on_failure($sformatf("Error: %s is 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    // Latest write to addr seen on the data bus
    task automatic check_store(input logic [31:0] addr, input logic [31:0] want);
        int hit;
        hit = -1;
        foreach (dbus_adr_log[i]) begin
            if (dbus_we_log[i] && dbus_adr_log[i] == addr) hit = i;
        end
        if (hit < 0) begin
            stop_on_failure($sformatf("No store to data address 0x%08h reached the bus", addr));
        end else begin
            compare($sformatf("dbus_req.dat_w at 0x%08h", addr), dbus_dat_log[hit], want);
        end
    endtask

    // Unused words decode as illegal, so a runaway program halts
    task automatic start_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'b0000000};
            dmem[i] = 32'hd0d0_0000 | 32'(i);
        end
        prog_len = 0;
        fetch_log.delete();
        dbus_adr_log.delete();
        dbus_dat_log.delete();
        dbus_we_log.delete();
    endtask

    task automatic put_instr(input logic [31:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic reset_core();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!halted) begin
            if (cycles == 3000) begin
                stop_on_failure($sformatf("Timed out waiting for halted in the %s program", name));
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic run_program(input string name);
        reset_core();
        wait_for_halt(name);
    endtask

    task automatic alu_ops_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] want [13];
        a = 32'h0000_0123;
        b = 32'hffff_fffb;
        want[0]  = a + b;
        want[1]  = a - b;
        want[2]  = a << 2;
        want[3]  = b >> 2;
        want[4]  = {2'b11, b[31:2]};
        want[5]  = a << 4;
        want[6]  = {1'b1, b[31:1]};
        want[7]  = 32'd1;
        want[8]  = 32'd0;
        want[9]  = a ^ b;
        want[10] = a | b;
        want[11] = a & b;
        want[12] = a + 32'h7ff;
        start_program();
        put_instr(addi(5'd1, 5'd0, 12'h123));
        put_instr(addi(5'd2, 5'd0, 12'hffb));
        put_instr(addi(5'd6, 5'd0, 12'd2));
        put_instr(r_type(7'h00, 3'b000, 5'd10, 5'd1, 5'd2));
        put_instr(r_type(7'h20, 3'b000, 5'd11, 5'd1, 5'd2));
        put_instr(r_type(7'h00, 3'b001, 5'd12, 5'd1, 5'd6));
        put_instr(r_type(7'h00, 3'b101, 5'd13, 5'd2, 5'd6));
        put_instr(r_type(7'h20, 3'b101, 5'd14, 5'd2, 5'd6));
        put_instr(i_type(OPC_IMM, 3'b001, 5'd15, 5'd1, {7'h00, 5'd4}));
        put_instr(i_type(OPC_IMM, 3'b101, 5'd16, 5'd2, {7'h20, 5'd1}));
        put_instr(r_type(7'h00, 3'b010, 5'd17, 5'd2, 5'd1));
        put_instr(r_type(7'h00, 3'b011, 5'd18, 5'd2, 5'd1));
        put_instr(r_type(7'h00, 3'b100, 5'd19, 5'd1, 5'd2));
        put_instr(r_type(7'h00, 3'b110, 5'd20, 5'd1, 5'd2));
        put_instr(r_type(7'h00, 3'b111, 5'd21, 5'd1, 5'd2));
        put_instr(addi(5'd22, 5'd1, 12'h7ff));
        for (int k = 0; k < 13; k++) begin
            put_instr(sw(5'(10 + k), 5'd0, 12'(32'h100 + 4 * k)));
        end
        put_instr(ECALL);
        run_program("ALU");
        compare("illegal", 32'(illegal), 32'd0);
        for (int k = 0; k < 13; k++) begin
            check_store(32'h100 + 32'(4 * k), want[k]);
        end
    endtask

    task automatic upper_imm_test();
        start_program();
        put_instr(u_type(OPC_LUI, 5'd1, 20'habcde));
        put_instr(u_type(OPC_AUIPC, 5'd2, 20'h12345));
        put_instr(u_type(OPC_AUIPC, 5'd3, 20'hfffff));
        put_instr(sw(5'd1, 5'd0, 12'h140));
        put_instr(sw(5'd2, 5'd0, 12'h144));
        put_instr(sw(5'd3, 5'd0, 12'h148));
        put_instr(ECALL);
        run_program("upper immediate");
        check_store(32'h140, {20'habcde, 12'h000});
        check_store(32'h144, {20'h12345, 12'h000} + 32'd4);
        check_store(32'h148, {20'hfffff, 12'h000} + 32'd8);
    endtask

    // x1 = -3, x2 = x3 = 5; marker x7 is 2 on the taken path, 1 otherwise
    task automatic branch_test();
        logic [2:0] f3s [6];
        logic [4:0] tk_a [6];
        logic [4:0] tk_b [6];
        logic [4:0] nt_a [6];
        logic [4:0] nt_b [6];
        f3s  = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        tk_a = '{5'd2, 5'd1, 5'd1, 5'd2, 5'd2, 5'd1};
        tk_b = '{5'd3, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
        nt_a = '{5'd1, 5'd2, 5'd2, 5'd1, 5'd1, 5'd2};
        nt_b = '{5'd2, 5'd3, 5'd1, 5'd2, 5'd2, 5'd1};
        start_program();
        put_instr(addi(5'd1, 5'd0, 12'hffd));
        put_instr(addi(5'd2, 5'd0, 12'd5));
        put_instr(addi(5'd3, 5'd0, 12'd5));
        for (int k = 0; k < 12; k++) begin
            if (k % 2 == 0) begin
                put_instr(b_type(f3s[k / 2], tk_a[k / 2], tk_b[k / 2], 13'd12));
            end else begin
                put_instr(b_type(f3s[k / 2], nt_a[k / 2], nt_b[k / 2], 13'd12));
            end
            put_instr(addi(5'd7, 5'd0, 12'd1));
            put_instr(j_type(5'd0, 21'd8));
            put_instr(addi(5'd7, 5'd0, 12'd2));
            put_instr(sw(5'd7, 5'd0, 12'(32'h180 + 4 * k)));
        end
        put_instr(ECALL);
        run_program("branch");
        for (int k = 0; k < 12; k++) begin
            check_store(32'h180 + 32'(4 * k), (k % 2 == 0) ? 32'd2 : 32'd1);
        end
    endtask

    task automatic jump_test();
        logic [31:0] want_pc [10];
        want_pc = '{32'd0, 32'd12, 32'd16, 32'd20, 32'd32,
                    32'd36, 32'd40, 32'd44, 32'd48, 32'd52};
        start_program();
        put_instr(j_type(5'd1, 21'd12));
        put_instr(addi(5'd5, 5'd0, 12'hbad));
        put_instr(ECALL);
        put_instr(addi(5'd5, 5'd0, 12'h011));
        // The odd sum 29 + 4 must land on 32
        put_instr(addi(5'd6, 5'd0, 12'd29));
        put_instr(i_type(OPC_JALR, 3'b000, 5'd2, 5'd6, 12'd4));
        put_instr(addi(5'd5, 5'd0, 12'hbad));
        put_instr(ECALL);
        put_instr(addi(5'd7, 5'd0, 12'h022));
        put_instr(sw(5'd1, 5'd0, 12'h1c0));
        put_instr(sw(5'd2, 5'd0, 12'h1c4));
        put_instr(sw(5'd5, 5'd0, 12'h1c8));
        put_instr(sw(5'd7, 5'd0, 12'h1cc));
        put_instr(ECALL);
        run_program("jump");
        check_store(32'h1c0, 32'd0 + 32'd4);
        check_store(32'h1c4, 32'd20 + 32'd4);
        check_store(32'h1c8, 32'h011);
        check_store(32'h1cc, 32'h022);
        compare("instruction fetch count", 32'(fetch_log.size()), 32'd10);
        for (int i = 0; i < 10; i++) begin
            compare($sformatf("ibus_req.adr of fetch %0d", i), fetch_log[i], want_pc[i]);
        end
    endtask

    task automatic load_store_test();
        logic [31:0] want_adr [4];
        logic [31:0] want_dat [4];
        start_program();
        dmem[128] = 32'h1234_5678;
        dmem[129] = 32'h8000_0001;
        dmem[130] = 32'h0f0f_0f0f;
        want_adr = '{32'h240, 32'h244, 32'h248, 32'h24c};
        want_dat = '{dmem[128] + 32'd1, dmem[129] + dmem[129], ~dmem[130], 32'd0};
        put_instr(addi(5'd8, 5'd0, 12'h200));
        put_instr(lw(5'd1, 5'd8, 12'd0));
        put_instr(lw(5'd2, 5'd8, 12'd4));
        put_instr(lw(5'd3, 5'd8, 12'd8));
        // Both writes to x0 must be dropped
        put_instr(lw(5'd0, 5'd8, 12'd0));
        put_instr(addi(5'd0, 5'd0, 12'h055));
        put_instr(addi(5'd4, 5'd1, 12'd1));
        put_instr(r_type(7'h00, 3'b000, 5'd5, 5'd2, 5'd2));
        put_instr(i_type(OPC_IMM, 3'b100, 5'd6, 5'd3, 12'hfff));
        put_instr(sw(5'd4, 5'd8, 12'h040));
        put_instr(sw(5'd5, 5'd8, 12'h044));
        put_instr(sw(5'd6, 5'd8, 12'h048));
        put_instr(sw(5'd0, 5'd8, 12'h04c));
        put_instr(ECALL);
        run_program("load and store");
        compare("data bus cycle count", 32'(dbus_adr_log.size()), 32'd8);
        for (int i = 0; i < 4; i++) begin
            compare($sformatf("dbus_req.we of load %0d", i), 32'(dbus_we_log[i]), 32'd0);
            compare($sformatf("dbus_req.adr of load %0d", i), dbus_adr_log[i],
                    32'h200 + 32'(4 * (i % 3)));
            compare($sformatf("dbus_req.we of store %0d", i), 32'(dbus_we_log[i + 4]), 32'd1);
            compare($sformatf("dbus_req.adr of store %0d", i), dbus_adr_log[i + 4], want_adr[i]);
            compare($sformatf("dbus_req.dat_w of store %0d", i), dbus_dat_log[i + 4],
                    want_dat[i]);
        end
    endtask

    task automatic halt_test();
        start_program();
        put_instr(addi(5'd1, 5'd0, 12'd1));
        put_instr(32'h0000_007f);
        put_instr(addi(5'd1, 5'd0, 12'd2));
        run_program("illegal opcode");
        // Give fetch time to show any unwanted bus cycle
        repeat (10) @(negedge clk);
        compare("halted", 32'(halted), 32'd1);
        compare("illegal", 32'(illegal), 32'd1);
        compare("ibus_req.cyc", 32'(ibus_req.cyc), 32'd0);
        compare("instruction fetch count", 32'(fetch_log.size()), 32'd2);
        compare("ibus_req.adr of last fetch", fetch_log[fetch_log.size() - 1], 32'd4);

        start_program();
        put_instr(addi(5'd1, 5'd0, 12'd1));
        put_instr(EBREAK);
        run_program("EBREAK");
        compare("illegal", 32'(illegal), 32'd0);
    endtask

    initial begin
        void'($urandom(32'head3_16a9));
        rst_n = 1'b0;
        alu_ops_test();
        upper_imm_test();
        branch_test();
        jump_test();
        load_store_test();
        halt_test();
        $display("test passed");
        $finish;
    end

endmodule
